//--- common/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluOr  = 4'd2
    } aluOpE;

    typedef enum logic {
        srcRt  = 1'b0,
        srcImm = 1'b1
    } aluSrcE;

    typedef enum logic [1:0] {
        regSrcAlu  = 2'd0,
        regSrcMem  = 2'd1,
        regSrcLink = 2'd2
    } regSrcE;

    typedef enum logic [1:0] {
        regDstRd = 2'd0,
        regDstRt = 2'd1,
        regDstRa = 2'd2
    } regDstE;

    typedef enum logic [1:0] {
        extZero  = 2'd0,
        extSign  = 2'd1,
        extUpper = 2'd2
    } extOpE;

    typedef enum logic {
        brNone = 1'b0,
        brZero = 1'b1
    } branchE;

    typedef enum logic [1:0] {
        jumpNone  = 2'd0,
        jumpIndex = 2'd1,
        jumpReg   = 2'd2
    } jumpE;

    typedef struct packed {
        aluOpE  aluOp;
        aluSrcE aluSrc;
        regSrcE regSrc;
        regDstE regDst;
        extOpE  extOp;
        branchE branch;
        jumpE   jump;
        logic   regWrite;
        logic   memWrite;
    } ctrlT;

    // no write, no jump, pc steps by four
    localparam ctrlT ctrlNop = '{
        aluOp:    aluAdd,
        aluSrc:   srcRt,
        regSrc:   regSrcAlu,
        regDst:   regDstRd,
        extOp:    extZero,
        branch:   brNone,
        jump:     jumpNone,
        regWrite: 1'b0,
        memWrite: 1'b0
    };

endpackage

`default_nettype wire

//--- common/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef enum logic [5:0] {
        opRtype = 6'b000000,
        opJal   = 6'b000011,
        opBeq   = 6'b000100,
        opOri   = 6'b001101,
        opLui   = 6'b001111,
        opLw    = 6'b100011,
        opSw    = 6'b101011
    } opcodeE;

    typedef enum logic [5:0] {
        functJr  = 6'b001000,
        functAdd = 6'b100000,
        functSub = 6'b100010
    } functE;

    localparam logic [4:0] regRa = 5'd31; // link register for jal

    typedef struct packed {
        opcodeE     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        functE      funct;
    } rTypeT;

    typedef struct packed {
        opcodeE      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iTypeT;

    typedef struct packed {
        opcodeE      opcode;
        logic [25:0] index26;
    } jTypeT;

    // same 32 bits seen through each format
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        jTypeT jType;
    } instrU;

endpackage

`default_nettype wire

//--- decode/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  isaPkg::instrU  instr,
    output ctrlPkg::ctrlT  ctrl,
    output logic [31:0]    extImm
);

    logic [15:0] imm;

    assign imm = instr.iType.imm16;

    always_comb begin
        ctrl = ctrlPkg::ctrlNop;
        case (instr.rType.opcode)
            isaPkg::opRtype: begin
                case (instr.rType.funct)
                    isaPkg::functAdd: begin
                        ctrl.aluOp    = ctrlPkg::aluAdd;
                        ctrl.regDst   = ctrlPkg::regDstRd;
                        ctrl.regWrite = 1'b1;
                    end
                    isaPkg::functSub: begin
                        ctrl.aluOp    = ctrlPkg::aluSub;
                        ctrl.regDst   = ctrlPkg::regDstRd;
                        ctrl.regWrite = 1'b1;
                    end
                    isaPkg::functJr: begin
                        ctrl.jump = ctrlPkg::jumpReg;
                    end
                    default: begin
                        ctrl = ctrlPkg::ctrlNop; // unknown funct
                    end
                endcase
            end
            isaPkg::opOri: begin
                ctrl.aluOp    = ctrlPkg::aluOr;
                ctrl.aluSrc   = ctrlPkg::srcImm;
                ctrl.regDst   = ctrlPkg::regDstRt;
                ctrl.extOp    = ctrlPkg::extZero;
                ctrl.regWrite = 1'b1;
            end
            isaPkg::opLw: begin
                ctrl.aluSrc   = ctrlPkg::srcImm;
                ctrl.regSrc   = ctrlPkg::regSrcMem;
                ctrl.regDst   = ctrlPkg::regDstRt;
                ctrl.extOp    = ctrlPkg::extSign;
                ctrl.regWrite = 1'b1;
            end
            isaPkg::opSw: begin
                ctrl.aluSrc   = ctrlPkg::srcImm;
                ctrl.extOp    = ctrlPkg::extSign;
                ctrl.memWrite = 1'b1;
            end
            isaPkg::opBeq: begin
                ctrl.aluOp  = ctrlPkg::aluSub; // equal when difference is zero
                ctrl.extOp  = ctrlPkg::extSign;
                ctrl.branch = ctrlPkg::brZero;
            end
            isaPkg::opLui: begin
                ctrl.aluOp    = ctrlPkg::aluOr;
                ctrl.aluSrc   = ctrlPkg::srcImm;
                ctrl.regDst   = ctrlPkg::regDstRt;
                ctrl.extOp    = ctrlPkg::extUpper;
                ctrl.regWrite = 1'b1;
            end
            isaPkg::opJal: begin
                ctrl.regSrc   = ctrlPkg::regSrcLink;
                ctrl.regDst   = ctrlPkg::regDstRa;
                ctrl.jump     = ctrlPkg::jumpIndex;
                ctrl.regWrite = 1'b1;
            end
            default: begin
                ctrl = ctrlPkg::ctrlNop;
            end
        endcase
    end

    always_comb begin
        case (ctrl.extOp)
            ctrlPkg::extSign:  extImm = {{16{imm[15]}}, imm};
            ctrlPkg::extUpper: extImm = {imm, 16'h0000};
            default:           extImm = {16'h0000, imm};
        endcase
    end

endmodule

`default_nettype wire

//--- execute/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  ctrlPkg::ctrlT ctrl,
    input  logic [31:0]   rsData,
    input  logic [31:0]   rtData,
    input  logic [31:0]   extImm,
    output logic [31:0]   aluResult,
    output logic          takeBranch
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic        isZero;

    assign opA = rsData;
    assign opB = (ctrl.aluSrc == ctrlPkg::srcImm) ? extImm : rtData;

    always_comb begin
        case (ctrl.aluOp)
            ctrlPkg::aluAdd: aluResult = opA + opB;
            ctrlPkg::aluSub: aluResult = opA - opB;
            ctrlPkg::aluOr:  aluResult = opA | opB;
            default:         aluResult = opA + opB;
        endcase
    end

    assign isZero = (aluResult == 32'd0);

    // beq only, rs - rt == 0
    assign takeBranch = (ctrl.branch == ctrlPkg::brZero) && isZero;

endmodule

`default_nettype wire

//--- mipsCore.f
common/isaPkg.sv
common/ctrlPkg.sv
decode/instrDecoder.sv
execute/aluUnit.sv
verilog/regFile.sv
verilog/pcUnit.sv
verilog/resultSelect.sv
verilog/mipsCore.sv
testbench/mipsCoreChecker.sv
testbench/mipsCoreTb.sv

//--- runSim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f mipsCore.f --top-module mipsCoreTb -Mdir obj_dir -o mipsCoreSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/mipsCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -Fqx 'All tests passed!' "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

//--- testbench/mipsCoreChecker.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreChecker #(
    parameter logic [31:0] RESET_PC    = 32'h0000_3000,
    parameter int          RESET_LIMIT = 8
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        expValid,
    input  logic [31:0] expPc,
    input  logic        expRegWe,
    input  logic [4:0]  expRegWaddr,
    input  logic [31:0] expRegWdata,
    input  logic [1:0]  expMemMode,
    input  logic [31:0] expMemAddr,
    input  logic [31:0] expMemWdata,
    input  logic [31:0] pc,
    input  logic        regWe,
    input  logic [4:0]  regWaddr,
    input  logic [31:0] regWdata,
    input  logic        memWe,
    input  logic [31:0] memAddr,
    input  logic [31:0] memWdata,
    output int          mismatchCount = 0,
    output int          timeoutCount = 0,
    output int          checkCount = 0
);

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns: %s expected %b, got %b", $time, name, expected, actual);
            mismatchCount++;
        end
    endtask

    // falling edge, everything settled since the rising edge
    always @(negedge clk) begin
        if (!arstN) begin
            checkWord("pc", RESET_PC, pc);
            checkBit("regWe", 1'b0, regWe);
            checkBit("memWe", 1'b0, memWe);
        end else if (expValid) begin
            checkCount++;
            checkWord("pc", expPc, pc);
            checkBit("regWe", expRegWe, regWe);
            if (expRegWe) begin
                checkWord("regWaddr", {27'd0, expRegWaddr}, {27'd0, regWaddr});
                checkWord("regWdata", expRegWdata, regWdata);
            end
            checkBit("memWe", expMemMode == 2'd1, memWe);
            if (expMemMode != 2'd0) begin
                checkWord("memAddr", expMemAddr, memAddr); // loads and stores
            end
            if (expMemMode == 2'd1) begin
                checkWord("memWdata", expMemWdata, memWdata);
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!arstN && cycles < RESET_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!arstN) begin
            $display("timeout: reset was not released within %0d cycles", RESET_LIMIT);
            timeoutCount++;
        end
    end

endmodule

`default_nettype wire

//--- testbench/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;

    localparam logic [31:0] RESET_PC     = 32'h0000_3000;
    localparam logic [31:0] SEED         = 32'h8a2c_97be;
    localparam int          NUM_VECTORS  = 22;
    localparam int          FIELDS       = 9;
    localparam int          RESET_CYCLES = 3;
    localparam int          DRAIN_LIMIT  = 10;

    logic          clk;
    logic          arstN;
    isaPkg::instrU instr;
    logic [31:0]   memRdata;
    logic [31:0]   pc;
    logic [31:0]   memAddr;
    logic [31:0]   memWdata;
    logic          memWe;
    logic          regWe;
    logic [4:0]    regWaddr;
    logic [31:0]   regWdata;

    logic          expValid;
    logic [31:0]   expPc;
    logic          expRegWe;
    logic [4:0]    expRegWaddr;
    logic [31:0]   expRegWdata;
    logic [1:0]    expMemMode;
    logic [31:0]   expMemAddr;
    logic [31:0]   expMemWdata;

    logic [31:0]   vecMem [NUM_VECTORS*FIELDS];
    int            mismatchCount;
    int            timeoutCount;
    int            checkCount;
    int            drainTimeouts;

    always #10 clk = ~clk;

    mipsCore #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk      (clk),
        .arstN    (arstN),
        .pc       (pc),
        .instr    (instr),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memWe    (memWe),
        .memRdata (memRdata),
        .regWe    (regWe),
        .regWaddr (regWaddr),
        .regWdata (regWdata)
    );

    mipsCoreChecker #(
        .RESET_PC (RESET_PC)
    ) uChecker (
        .clk           (clk),
        .arstN         (arstN),
        .expValid      (expValid),
        .expPc         (expPc),
        .expRegWe      (expRegWe),
        .expRegWaddr   (expRegWaddr),
        .expRegWdata   (expRegWdata),
        .expMemMode    (expMemMode),
        .expMemAddr    (expMemAddr),
        .expMemWdata   (expMemWdata),
        .pc            (pc),
        .regWe         (regWe),
        .regWaddr      (regWaddr),
        .regWdata      (regWdata),
        .memWe         (memWe),
        .memAddr       (memAddr),
        .memWdata      (memWdata),
        .mismatchCount (mismatchCount),
        .timeoutCount  (timeoutCount),
        .checkCount    (checkCount)
    );

    task automatic driveVector(input int v);
        int base;
        base = v * FIELDS;
        instr       <= vecMem[base];
        memRdata    <= vecMem[base + 1];
        expPc       <= vecMem[base + 2];
        expRegWe    <= vecMem[base + 3][0];
        expRegWaddr <= vecMem[base + 4][4:0];
        expRegWdata <= vecMem[base + 5];
        expMemMode  <= vecMem[base + 6][1:0];
        expMemAddr  <= vecMem[base + 7];
        expMemWdata <= vecMem[base + 8];
        expValid    <= 1'b1;
    endtask

    initial begin
        int waitCycles;
        void'($urandom(SEED));
        clk           = 1'b0;
        arstN         = 1'b0;
        instr         = '0;
        memRdata      = '0;
        expValid      = 1'b0;
        expPc         = '0;
        expRegWe      = 1'b0;
        expRegWaddr   = '0;
        expRegWdata   = '0;
        expMemMode    = '0;
        expMemAddr    = '0;
        expMemWdata   = '0;
        drainTimeouts = 0;
        $readmemh("testbench/mipsCoreVectors.txt", vecMem);

        // ori $10 and sw $10 under reset, both strobes must stay low
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            instr    <= (i % 2 == 0) ? 32'h340A_00FF : 32'hAC0A_0000;
            memRdata <= $urandom;
        end

        for (int v = 0; v < NUM_VECTORS; v++) begin
            @(posedge clk);
            if (v == 0) begin
                arstN <= 1'b1; // release with the first vector
            end
            driveVector(v);
        end
        @(posedge clk);
        expValid <= 1'b0;
        instr    <= '0;

        waitCycles = 0;
        while (checkCount < NUM_VECTORS && waitCycles < DRAIN_LIMIT) begin
            @(posedge clk);
            waitCycles++;
        end
        if (checkCount < NUM_VECTORS) begin
            $display("timeout: only %0d of %0d vectors were checked", checkCount, NUM_VECTORS);
            drainTimeouts++;
        end

        $display("vectors checked %0d, mismatches %0d, timeouts %0d",
                 checkCount, mismatchCount, timeoutCount + drainTimeouts);
        if (mismatchCount == 0 && timeoutCount + drainTimeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/mipsCoreVectors.txt
// instr memRdata pc regWe regWaddr regWdata memMode memAddr memWdata
// memMode: 0 no access, 1 store (memWe high), 2 load (address only)
34018004 00000000 00003000 1 01 00008004 0 00000000 00000000
3C021234 00000000 00003004 1 02 12340000 0 00000000 00000000
34425678 00000000 00003008 1 02 12345678 0 00000000 00000000
00221820 00000000 0000300C 1 03 1234D67C 0 00000000 00000000
00222022 00000000 00003010 1 04 EDCC298C 0 00000000 00000000
00220020 00000000 00003014 0 00 00000000 0 00000000 00000000
AC23FFF8 00000000 00003018 0 00 00000000 1 00007FFC 1234D67C
8C25FFFC CAFEF00D 0000301C 1 05 CAFEF00D 2 00008000 00000000
10210002 00000000 00003020 0 00 00000000 0 00000000 00000000
10220005 00000000 0000302C 0 00 00000000 0 00000000 00000000
1000FFFD 00000000 00003030 0 00 00000000 0 00000000 00000000
0C000C40 00000000 00003028 1 1F 0000302C 0 00000000 00000000
20010007 00000000 00003100 0 00 00000000 0 00000000 00000000
00223024 00000000 00003104 0 00 00000000 0 00000000 00000000
03E03020 5A5A5A5A 00003108 1 06 0000302C 0 00000000 00000000
03E00008 00000000 0000310C 0 00 00000000 0 00000000 00000000
00833822 00000000 0000302C 1 07 DB975310 0 00000000 00000000
AC050004 00000000 00003030 0 00 00000000 1 00000004 CAFEF00D
34000001 00000000 00003034 0 00 00000000 0 00000000 00000000
FFFFFFFF 00000000 00003038 0 00 00000000 0 00000000 00000000
00E54820 00000000 0000303C 1 09 A696431D 0 00000000 00000000
01405820 00000000 00003040 1 0B 00000000 0 00000000 00000000

//--- verilog/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
    parameter logic [31:0] RESET_PC = 32'h0000_3000
) (
    input  logic          clk,
    input  logic          arstN,
    output logic [31:0]   pc,
    input  isaPkg::instrU instr,
    output logic [31:0]   memAddr,
    output logic [31:0]   memWdata,
    output logic          memWe,
    input  logic [31:0]   memRdata,
    output logic          regWe,
    output logic [4:0]    regWaddr,
    output logic [31:0]   regWdata
);

    ctrlPkg::ctrlT ctrl;
    logic [31:0]   extImm;
    logic [31:0]   rsData;
    logic [31:0]   rtData;
    logic [31:0]   aluResult;
    logic          takeBranch;
    logic [31:0]   linkAddr;
    logic          wbWe;

    // strobes held low while in reset
    assign regWe    = wbWe && arstN;
    assign memWe    = ctrl.memWrite && arstN;
    assign memAddr  = aluResult;
    assign memWdata = rtData;

    instrDecoder uDecoder (
        .instr  (instr),
        .ctrl   (ctrl),
        .extImm (extImm)
    );

    regFile uRegFile (
        .clk    (clk),
        .arstN  (arstN),
        .rsAddr (instr.rType.rs),
        .rtAddr (instr.rType.rt),
        .rsData (rsData),
        .rtData (rtData),
        .we     (regWe),
        .waddr  (regWaddr),
        .wdata  (regWdata)
    );

    aluUnit uAlu (
        .ctrl       (ctrl),
        .rsData     (rsData),
        .rtData     (rtData),
        .extImm     (extImm),
        .aluResult  (aluResult),
        .takeBranch (takeBranch)
    );

    resultSelect uResult (
        .ctrl      (ctrl),
        .instr     (instr),
        .aluResult (aluResult),
        .memRdata  (memRdata),
        .linkAddr  (linkAddr),
        .wdata     (regWdata),
        .waddr     (regWaddr),
        .we        (wbWe)
    );

    pcUnit #(
        .RESET_PC (RESET_PC)
    ) uPc (
        .clk        (clk),
        .arstN      (arstN),
        .ctrl       (ctrl),
        .instr      (instr),
        .takeBranch (takeBranch),
        .rsData     (rsData),
        .pc         (pc),
        .linkAddr   (linkAddr)
    );

endmodule

`default_nettype wire

//--- verilog/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit #(
    parameter logic [31:0] RESET_PC = 32'h0000_3000
) (
    input  logic          clk,
    input  logic          arstN,
    input  ctrlPkg::ctrlT ctrl,
    input  isaPkg::instrU instr,
    input  logic          takeBranch,
    input  logic [31:0]   rsData,
    output logic [31:0]   pc,
    output logic [31:0]   linkAddr
);

    logic [31:0] pcPlus4;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;
    logic [15:0] offset;

    assign offset       = instr.iType.imm16;
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{offset[15]}}, offset, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], instr.jType.index26, 2'b00};
    assign linkAddr     = pcPlus4;

    always_comb begin
        if (ctrl.jump == ctrlPkg::jumpReg) begin
            nextPc = rsData;
        end else if (ctrl.jump == ctrlPkg::jumpIndex) begin
            nextPc = jumpTarget;
        end else if (takeBranch) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    output logic [31:0] rsData,
    output logic [31:0] rtData,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // no bypass, old value until the edge
    assign rsData = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
    assign rtData = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

endmodule

`default_nettype wire

//--- verilog/resultSelect.sv
`timescale 1ns/1ps
`default_nettype none

module resultSelect (
    input  ctrlPkg::ctrlT ctrl,
    input  isaPkg::instrU instr,
    input  logic [31:0]   aluResult,
    input  logic [31:0]   memRdata,
    input  logic [31:0]   linkAddr,
    output logic [31:0]   wdata,
    output logic [4:0]    waddr,
    output logic          we
);

    always_comb begin
        case (ctrl.regSrc)
            ctrlPkg::regSrcMem:  wdata = memRdata;
            ctrlPkg::regSrcLink: wdata = linkAddr; // jal return address
            default:             wdata = aluResult;
        endcase
    end

    always_comb begin
        case (ctrl.regDst)
            ctrlPkg::regDstRt: waddr = instr.rType.rt;
            ctrlPkg::regDstRa: waddr = isaPkg::regRa;
            default:           waddr = instr.rType.rd;
        endcase
    end

    // writes to $zero are dropped
    assign we = ctrl.regWrite && (waddr != 5'd0);

endmodule

`default_nettype wire
